// ==== include/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Datapath width
`define RV_XLEN 32

// Architectural register count
`define RV_NREGS 32

// Instruction memory, word-address width
`define RV_IMEM_AW 6

// Data memory, word-address width
`define RV_DMEM_AW 6

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

        // Datum or instruction word
        typedef logic [`RV_XLEN-1:0] word_t;
        typedef logic [4:0] reg_addr_t;
        typedef logic [`RV_IMEM_AW-1:0] imem_addr_t;
        // Sign-extended I, S or B immediate
        typedef logic [31:0] imm_t;

        // Major opcodes handled by decode
        typedef enum logic [6:0] {
                OP     = 7'b0110011,
                OP_IMM = 7'b0010011,
                LOAD   = 7'b0000011,
                STORE  = 7'b0100011,
                BRANCH = 7'b1100011
        } opcode_t;

        typedef enum logic [2:0] {
                ALU_ADD,
                ALU_SUB,
                ALU_AND,
                ALU_OR,
                ALU_XOR,
                ALU_SLT,
                ALU_SLL,
                ALU_SRL
        } alu_op_t;

        // Operand source in execute
        typedef enum logic [1:0] {
                NONE,
                EX_MEM,
                MEM_WB
        } fwd_sel_t;

endpackage

`default_nettype wire

// ==== hw/pipeline_if.sv ====
`default_nettype none

// ID/EX pipeline register contents
interface id_ex_if;
        rv_pkg::reg_addr_t rs1, rs2, rd;
        rv_pkg::word_t rs1_data, rs2_data;
        rv_pkg::imm_t imm;
        rv_pkg::alu_op_t alu_op;
        logic alu_src, mem_write, mem2reg, reg_write;

        modport producer (output rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
                alu_src, mem_write, mem2reg, reg_write);
        modport consumer (input rs1, rs2, rd, rs1_data, rs2_data, imm, alu_op,
                alu_src, mem_write, mem2reg, reg_write);
endinterface

// EX/MEM pipeline register contents
interface ex_mem_if;
        rv_pkg::word_t alu_result, write_data;
        rv_pkg::reg_addr_t rd;
        logic mem_write, mem2reg, reg_write;

        modport producer (output alu_result, write_data, rd, mem_write, mem2reg, reg_write);
        modport consumer (input alu_result, write_data, rd, mem_write, mem2reg, reg_write);
        // Read-only view for forwarding
        modport monitor (input alu_result, rd, reg_write);
endinterface

// MEM/WB pipeline register contents
interface mem_wb_if;
        rv_pkg::reg_addr_t rd;
        rv_pkg::word_t wb_data;
        logic reg_write;

        modport producer (output rd, wb_data, reg_write);
        modport consumer (input rd, wb_data, reg_write);
endinterface

`default_nettype wire

// ==== hw/instruction_fetch.sv ====
`default_nettype none

`include "rv_defs.svh"

module instruction_fetch (
        input  wire logic               i_clk,
        input  wire logic               i_reset,
        input  wire logic               i_run,
        input  wire logic               i_imem_we,
        input  wire rv_pkg::imem_addr_t i_imem_addr,
        input  wire rv_pkg::word_t      i_imem_wdata,
        input  wire logic               i_branch_taken,
        input  wire rv_pkg::imm_t       i_branch_imm,
        output rv_pkg::word_t           o_instruction
);

        rv_pkg::word_t imem [2**`RV_IMEM_AW];
        rv_pkg::word_t pc;
        // PC of the word now in IF/ID, base of the branch target
        rv_pkg::word_t if_id_pc;
        rv_pkg::imem_addr_t fetch_addr;
        logic run_q;

        // Byte PC to word index
        assign fetch_addr = pc[`RV_IMEM_AW+1:2];

        // Program load port
        always_ff @(posedge i_clk)
        begin
                if (i_imem_we)
                        imem[i_imem_addr] <= i_imem_wdata;
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        run_q         <= 1'b0;
                        pc            <= '0;
                        if_id_pc      <= '0;
                        o_instruction <= '0;
                end
                else
                begin
                        run_q <= i_run;
                        if (run_q)
                        begin
                                o_instruction <= imem[fetch_addr];
                                if_id_pc      <= pc;
                                // Delay slot is already being fetched
                                if (i_branch_taken)
                                        pc <= if_id_pc + i_branch_imm;
                                else
                                        pc <= pc + 32'd4;
                        end
                        else
                                // Idle, feed bubbles
                                o_instruction <= '0;
                end
        end

endmodule

`default_nettype wire

// ==== hw/instruction_decode.sv ====
`default_nettype none

module instruction_decode (
        input  wire logic          i_clk,
        input  wire logic          i_reset,
        input  wire rv_pkg::word_t i_instruction,
        output rv_pkg::reg_addr_t  o_rs1,
        output rv_pkg::reg_addr_t  o_rs2,
        input  wire rv_pkg::word_t i_rs1_data,
        input  wire rv_pkg::word_t i_rs2_data,
        output logic               o_branch_taken,
        output rv_pkg::imm_t       o_branch_imm,
        id_ex_if.producer          id_ex
);

        rv_pkg::opcode_t opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        rv_pkg::reg_addr_t rd;
        rv_pkg::imm_t imm;
        rv_pkg::alu_op_t alu_op;
        logic alu_src, mem_write, mem2reg, reg_write;

        //////////////////////////////////////////////////////////////////////
        // Field extraction
        assign opcode = rv_pkg::opcode_t'(i_instruction[6:0]);
        assign rd     = i_instruction[11:7];
        assign funct3 = i_instruction[14:12];
        assign o_rs1  = i_instruction[19:15];
        assign o_rs2  = i_instruction[24:20];
        assign funct7 = i_instruction[31:25];

        assign o_branch_imm = imm;

        //////////////////////////////////////////////////////////////////////
        // Control and branch decision
        always_comb
        begin
                // Bubble unless matched below
                alu_op         = rv_pkg::ALU_ADD;
                alu_src        = 1'b0;
                mem_write      = 1'b0;
                mem2reg        = 1'b0;
                reg_write      = 1'b0;
                o_branch_taken = 1'b0;
                imm = {{20{i_instruction[31]}}, i_instruction[31:20]};

                case (opcode)
                rv_pkg::OP:
                begin
                        reg_write = 1'b1;
                        case (funct3)
                        3'd0: alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
                        3'd1: alu_op = rv_pkg::ALU_SLL;
                        3'd2: alu_op = rv_pkg::ALU_SLT;
                        3'd4: alu_op = rv_pkg::ALU_XOR;
                        3'd5: alu_op = rv_pkg::ALU_SRL;
                        3'd6: alu_op = rv_pkg::ALU_OR;
                        3'd7: alu_op = rv_pkg::ALU_AND;
                        default: reg_write = 1'b0;
                        endcase
                        // Only SUB may set funct7 bit 5
                        if (funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 == 3'd0))
                                reg_write = 1'b0;
                end
                rv_pkg::OP_IMM:
                begin
                        alu_src = 1'b1;
                        case (funct3)
                        3'd0: reg_write = 1'b1;
                        3'd6:
                        begin
                                alu_op    = rv_pkg::ALU_OR;
                                reg_write = 1'b1;
                        end
                        3'd7:
                        begin
                                alu_op    = rv_pkg::ALU_AND;
                                reg_write = 1'b1;
                        end
                        default: ;
                        endcase
                end
                rv_pkg::LOAD:
                begin
                        // LW only
                        alu_src   = 1'b1;
                        mem2reg   = (funct3 == 3'd2);
                        reg_write = (funct3 == 3'd2);
                end
                rv_pkg::STORE:
                begin
                        imm = {{20{i_instruction[31]}}, i_instruction[31:25],
                                i_instruction[11:7]};
                        alu_src   = 1'b1;
                        mem_write = (funct3 == 3'd2);
                end
                rv_pkg::BRANCH:
                begin
                        imm = {{19{i_instruction[31]}}, i_instruction[31], i_instruction[7],
                                i_instruction[30:25], i_instruction[11:8], 1'b0};
                        // Raw register data, no forwarding here
                        if (funct3 == 3'd0)
                                o_branch_taken = (i_rs1_data == i_rs2_data);
                        else if (funct3 == 3'd1)
                                o_branch_taken = (i_rs1_data != i_rs2_data);
                end
                default: ;
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // ID/EX register
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        id_ex.rs1       <= '0;
                        id_ex.rs2       <= '0;
                        id_ex.rd        <= '0;
                        id_ex.rs1_data  <= '0;
                        id_ex.rs2_data  <= '0;
                        id_ex.imm       <= '0;
                        id_ex.alu_op    <= rv_pkg::ALU_ADD;
                        id_ex.alu_src   <= 1'b0;
                        id_ex.mem_write <= 1'b0;
                        id_ex.mem2reg   <= 1'b0;
                        id_ex.reg_write <= 1'b0;
                end
                else
                begin
                        id_ex.rs1       <= o_rs1;
                        id_ex.rs2       <= o_rs2;
                        id_ex.rd        <= rd;
                        id_ex.rs1_data  <= i_rs1_data;
                        id_ex.rs2_data  <= i_rs2_data;
                        id_ex.imm       <= imm;
                        id_ex.alu_op    <= alu_op;
                        id_ex.alu_src   <= alu_src;
                        id_ex.mem_write <= mem_write;
                        id_ex.mem2reg   <= mem2reg;
                        id_ex.reg_write <= reg_write;
                end
        end

endmodule

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none

`include "rv_defs.svh"

module register_file (
        input  wire logic              i_clk,
        input  wire logic              i_reset,
        input  wire logic              i_we,
        input  wire rv_pkg::reg_addr_t i_wr_addr,
        input  wire rv_pkg::word_t     i_wr_data,
        input  wire rv_pkg::reg_addr_t i_rd1_addr,
        input  wire rv_pkg::reg_addr_t i_rd2_addr,
        output rv_pkg::word_t          o_rd1_data,
        output rv_pkg::word_t          o_rd2_data
);

        rv_pkg::word_t regs [`RV_NREGS];

        // Read port, x0 is zero, write data bypassed
        function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
                if (addr == '0)
                        return '0;
                else if (i_we && i_wr_addr == addr)
                        return i_wr_data;
                else
                        return regs[addr];
        endfunction

        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        for (int i = 0; i < `RV_NREGS; i++)
                                regs[i] <= '0;
                end
                // Writes to x0 dropped
                else if (i_we && i_wr_addr != '0)
                        regs[i_wr_addr] <= i_wr_data;
        end

        always_comb
        begin
                o_rd1_data = read_port(i_rd1_addr);
                o_rd2_data = read_port(i_rd2_addr);
        end

endmodule

`default_nettype wire

// ==== hw/execute.sv ====
`default_nettype none

module execute (
        input  wire logic  i_clk,
        input  wire logic  i_reset,
        id_ex_if.consumer  id_ex,
        ex_mem_if.producer ex_mem,
        mem_wb_if.consumer mem_wb
);

        rv_pkg::fwd_sel_t fwd_a, fwd_b;
        rv_pkg::word_t op_a, rs2_val, op_b, alu_result;

        //////////////////////////////////////////////////////////////////////
        // Forwarding unit
        function automatic rv_pkg::fwd_sel_t fwd_select(input rv_pkg::reg_addr_t rs);
                rv_pkg::fwd_sel_t sel;
                sel = rv_pkg::NONE;
                // x0 never forwards
                if (rs != '0)
                begin
                        if (mem_wb.reg_write && mem_wb.rd == rs)
                                sel = rv_pkg::MEM_WB;
                        // Younger result wins
                        if (ex_mem.reg_write && ex_mem.rd == rs)
                                sel = rv_pkg::EX_MEM;
                end
                return sel;
        endfunction

        function automatic rv_pkg::word_t fwd_value(input rv_pkg::fwd_sel_t sel,
                                                    input rv_pkg::word_t reg_data);
                case (sel)
                rv_pkg::EX_MEM: return ex_mem.alu_result;
                rv_pkg::MEM_WB: return mem_wb.wb_data;
                default:        return reg_data;
                endcase
        endfunction

        always_comb
        begin
                fwd_a   = fwd_select(id_ex.rs1);
                fwd_b   = fwd_select(id_ex.rs2);
                // Operand muxes, rs2 value doubles as store data
                op_a    = fwd_value(fwd_a, id_ex.rs1_data);
                rs2_val = fwd_value(fwd_b, id_ex.rs2_data);
        end

        assign op_b = id_ex.alu_src ? id_ex.imm : rs2_val;

        //////////////////////////////////////////////////////////////////////
        // ALU
        always_comb
        begin
                case (id_ex.alu_op)
                rv_pkg::ALU_ADD: alu_result = op_a + op_b;
                rv_pkg::ALU_SUB: alu_result = op_a - op_b;
                rv_pkg::ALU_AND: alu_result = op_a & op_b;
                rv_pkg::ALU_OR:  alu_result = op_a | op_b;
                rv_pkg::ALU_XOR: alu_result = op_a ^ op_b;
                rv_pkg::ALU_SLT: alu_result = rv_pkg::word_t'($signed(op_a) < $signed(op_b));
                rv_pkg::ALU_SLL: alu_result = op_a << op_b[4:0];
                rv_pkg::ALU_SRL: alu_result = op_a >> op_b[4:0];
                default:         alu_result = op_a + op_b;
                endcase
        end

        //////////////////////////////////////////////////////////////////////
        // EX/MEM register
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        ex_mem.alu_result <= '0;
                        ex_mem.write_data <= '0;
                        ex_mem.rd         <= '0;
                        ex_mem.mem_write  <= 1'b0;
                        ex_mem.mem2reg    <= 1'b0;
                        ex_mem.reg_write  <= 1'b0;
                end
                else
                begin
                        ex_mem.alu_result <= alu_result;
                        ex_mem.write_data <= rs2_val;
                        ex_mem.rd         <= id_ex.rd;
                        ex_mem.mem_write  <= id_ex.mem_write;
                        ex_mem.mem2reg    <= id_ex.mem2reg;
                        ex_mem.reg_write  <= id_ex.reg_write;
                end
        end

endmodule

`default_nettype wire

// ==== hw/memory_writeback.sv ====
`default_nettype none

`include "rv_defs.svh"

module memory_writeback (
        input  wire logic  i_clk,
        input  wire logic  i_reset,
        ex_mem_if.consumer ex_mem,
        mem_wb_if.producer mem_wb,
        output logic               o_rf_we,
        output rv_pkg::reg_addr_t  o_rf_addr,
        output rv_pkg::word_t      o_rf_data,
        output logic               o_wb_valid,
        output rv_pkg::reg_addr_t  o_wb_rd,
        output rv_pkg::word_t      o_wb_data
);

        rv_pkg::word_t dmem [2**`RV_DMEM_AW];
        logic [`RV_DMEM_AW-1:0] dmem_addr;
        rv_pkg::word_t load_data;

        // Word index from the byte address
        assign dmem_addr = ex_mem.alu_result[`RV_DMEM_AW+1:2];
        assign load_data = dmem[dmem_addr];

        always_ff @(posedge i_clk)
        begin
                if (ex_mem.mem_write)
                        dmem[dmem_addr] <= ex_mem.write_data;
        end

        // MEM/WB register, result already selected
        always_ff @(posedge i_clk)
        begin
                if (i_reset)
                begin
                        mem_wb.rd        <= '0;
                        mem_wb.wb_data   <= '0;
                        mem_wb.reg_write <= 1'b0;
                end
                else
                begin
                        mem_wb.rd        <= ex_mem.rd;
                        mem_wb.wb_data   <= ex_mem.mem2reg ? load_data : ex_mem.alu_result;
                        mem_wb.reg_write <= ex_mem.reg_write;
                end
        end

        // Register file write
        assign o_rf_we   = mem_wb.reg_write;
        assign o_rf_addr = mem_wb.rd;
        assign o_rf_data = mem_wb.wb_data;

        // Retire strobe, x0 writes hidden
        assign o_wb_valid = mem_wb.reg_write && (mem_wb.rd != '0);
        assign o_wb_rd    = mem_wb.rd;
        assign o_wb_data  = mem_wb.wb_data;

endmodule

`default_nettype wire

// ==== hw/risc_v.sv ====
`default_nettype none

module risc_v (
        input  wire logic               i_clk,
        input  wire logic               i_reset,
        input  wire logic               i_run,
        input  wire logic               i_imem_we,
        input  wire rv_pkg::imem_addr_t i_imem_addr,
        input  wire rv_pkg::word_t      i_imem_wdata,
        output logic                    o_wb_valid,
        output rv_pkg::reg_addr_t       o_wb_rd,
        output rv_pkg::word_t           o_wb_data
);

        // IF to ID
        rv_pkg::word_t if_id_instruction;
        // ID back to IF
        logic branch_taken;
        rv_pkg::imm_t branch_imm;
        // Register file read side
        rv_pkg::reg_addr_t rs1, rs2;
        rv_pkg::word_t rs1_data, rs2_data;
        // Register file write side, from WB
        logic rf_we;
        rv_pkg::reg_addr_t rf_addr;
        rv_pkg::word_t rf_data;

        id_ex_if  id_ex ();
        ex_mem_if ex_mem ();
        mem_wb_if mem_wb ();

        //////////////////////////////////////////////////////////////////////
        // Fetch
        instruction_fetch if_stage (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_run          (i_run),
                .i_imem_we      (i_imem_we),
                .i_imem_addr    (i_imem_addr),
                .i_imem_wdata   (i_imem_wdata),
                .i_branch_taken (branch_taken),
                .i_branch_imm   (branch_imm),
                .o_instruction  (if_id_instruction)
        );

        //////////////////////////////////////////////////////////////////////
        // Decode and registers
        instruction_decode id_stage (
                .i_clk          (i_clk),
                .i_reset        (i_reset),
                .i_instruction  (if_id_instruction),
                .o_rs1          (rs1),
                .o_rs2          (rs2),
                .i_rs1_data     (rs1_data),
                .i_rs2_data     (rs2_data),
                .o_branch_taken (branch_taken),
                .o_branch_imm   (branch_imm),
                .id_ex          (id_ex.producer)
        );

        register_file rf (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .i_we       (rf_we),
                .i_wr_addr  (rf_addr),
                .i_wr_data  (rf_data),
                .i_rd1_addr (rs1),
                .i_rd2_addr (rs2),
                .o_rd1_data (rs1_data),
                .o_rd2_data (rs2_data)
        );

        //////////////////////////////////////////////////////////////////////
        // Execute, memory and write-back
        execute ex_stage (
                .i_clk   (i_clk),
                .i_reset (i_reset),
                .id_ex   (id_ex.consumer),
                .ex_mem  (ex_mem.producer),
                .mem_wb  (mem_wb.consumer)
        );

        memory_writeback mem_wb_stage (
                .i_clk      (i_clk),
                .i_reset    (i_reset),
                .ex_mem     (ex_mem.consumer),
                .mem_wb     (mem_wb.producer),
                .o_rf_we    (rf_we),
                .o_rf_addr  (rf_addr),
                .o_rf_data  (rf_data),
                .o_wb_valid (o_wb_valid),
                .o_wb_rd    (o_wb_rd),
                .o_wb_data  (o_wb_data)
        );

endmodule

`default_nettype wire

// ==== testbench/risc_v_sva.sv ====
`default_nettype none

module risc_v_sva (
        input  wire logic              i_clk,
        input  wire logic              i_reset,
        input  wire logic              i_wb_valid,
        input  wire rv_pkg::reg_addr_t i_wb_rd,
        input  wire rv_pkg::word_t     i_wb_data
);

        timeunit 1ns;
        timeprecision 1ps;

        // Count of failed assertions
        int failures = 0;

        // MEM/WB cleared by reset, no strobe on the following cycle
        reset_quiet: assert property (@(posedge i_clk) i_reset |=> !i_wb_valid)
                else
                begin
                        failures++;
                        $error("retire strobe high during reset");
                end

        // x0 writes never retire
        rd_nonzero: assert property (@(posedge i_clk) disable iff (i_reset)
                i_wb_valid |-> (i_wb_rd != '0))
                else
                begin
                        failures++;
                        $error("retire strobe with destination x0");
                end

        data_known: assert property (@(posedge i_clk) disable iff (i_reset)
                i_wb_valid |-> !$isunknown(i_wb_data))
                else
                begin
                        failures++;
                        $error("retire data unknown while strobe high");
                end

endmodule

// Attached to the top level
bind risc_v risc_v_sva risc_v_sva_inst (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_wb_valid (o_wb_valid),
        .i_wb_rd    (o_wb_rd),
        .i_wb_data  (o_wb_data)
);

`default_nettype wire

// ==== testbench/tb_risc_v.sv ====
`default_nettype none

`include "rv_defs.svh"

module tb_risc_v;

        timeunit 1ns;
        timeprecision 1ps;

        localparam int PATTERN_DEPTH  = 256;
        localparam int DRIVE_DELAY    = 5;
        localparam int RETIRE_TIMEOUT = 200;
        // Park loop must stay silent this long, past a PC wrap to word 0
        localparam int QUIET_CYCLES   = 50;

        logic i_clk;
        logic i_reset;
        logic i_run;
        logic i_imem_we;
        rv_pkg::imem_addr_t i_imem_addr;
        rv_pkg::word_t i_imem_wdata;
        logic o_wb_valid;
        rv_pkg::reg_addr_t o_wb_rd;
        rv_pkg::word_t o_wb_data;

        // Program length, program, record count, records
        rv_pkg::word_t patterns [PATTERN_DEPTH];
        int prog_words;
        int num_records;
        int rec_base;

        risc_v risc_v_inst (
                .i_clk        (i_clk),
                .i_reset      (i_reset),
                .i_run        (i_run),
                .i_imem_we    (i_imem_we),
                .i_imem_addr  (i_imem_addr),
                .i_imem_wdata (i_imem_wdata),
                .o_wb_valid   (o_wb_valid),
                .o_wb_rd      (o_wb_rd),
                .o_wb_data    (o_wb_data)
        );

        // 100 ns period
        initial
        begin
                i_clk = 1'b0;
                forever
                        #50 i_clk = ~i_clk;
        end

        //////////////////////////////////////////////////////////////////////
        // Helpers
        task automatic abort_run();
                $display("Simulation failed");
                $fatal(1, "run aborted");
        endtask

        task automatic check_value(input string name, input rv_pkg::word_t expected,
                                   input rv_pkg::word_t actual);
                if (actual !== expected)
                begin
                        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
                        abort_run();
                end
        endtask

        // Program goes in while i_run is low
        task automatic load_program(input int count);
                for (int i = 0; i < count; i++)
                begin
                        @(posedge i_clk);
                        #DRIVE_DELAY;
                        i_imem_we    = 1'b1;
                        i_imem_addr  = rv_pkg::imem_addr_t'(i);
                        i_imem_wdata = patterns[1 + i];
                end
                @(posedge i_clk);
                #DRIVE_DELAY;
                i_imem_we = 1'b0;
        endtask

        // Outputs settle after the rising edge, so look at the falling one
        task automatic wait_for_retire(input int index);
                int cycles;
                cycles = 0;
                @(negedge i_clk);
                while (o_wb_valid !== 1'b1)
                begin
                        cycles++;
                        if (cycles >= RETIRE_TIMEOUT)
                        begin
                                $display("No retire arrived within %0d cycles for record %0d",
                                         RETIRE_TIMEOUT, index);
                                abort_run();
                        end
                        @(negedge i_clk);
                end
        endtask

        task automatic check_quiet();
                for (int i = 0; i < QUIET_CYCLES; i++)
                begin
                        @(negedge i_clk);
                        if (o_wb_valid !== 1'b0)
                        begin
                                $display("Unexpected retire of x%0d after the last record",
                                         o_wb_rd);
                                abort_run();
                        end
                end
        endtask

        // Bound checker failures stop the run
        always @(negedge i_clk)
        begin
                if (risc_v_inst.risc_v_sva_inst.failures != 0)
                begin
                        $display("An assertion in the bound checker failed");
                        abort_run();
                end
        end

        //////////////////////////////////////////////////////////////////////
        // Main sequence
        initial
        begin
                i_reset      = 1'b1;
                i_run        = 1'b0;
                i_imem_we    = 1'b0;
                i_imem_addr  = '0;
                i_imem_wdata = '0;

                $readmemh("testbench/risc_v_patterns.txt", patterns);
                if ($isunknown(patterns[0]))
                begin
                        $display("Patterns file could not be read");
                        abort_run();
                end
                prog_words = int'(patterns[0]);
                if (prog_words == 0 || prog_words > 2**`RV_IMEM_AW)
                begin
                        $display("Program length %0d does not fit the instruction memory",
                                 prog_words);
                        abort_run();
                end
                num_records = int'(patterns[prog_words + 1]);
                rec_base    = prog_words + 2;
                if (rec_base + 2 * num_records > PATTERN_DEPTH)
                begin
                        $display("Record count %0d runs past the patterns buffer", num_records);
                        abort_run();
                end

                repeat (10) @(posedge i_clk);
                #DRIVE_DELAY;
                i_reset = 1'b0;

                load_program(prog_words);
                @(posedge i_clk);
                #DRIVE_DELAY;
                i_run = 1'b1;

                // Retires come strictly in program order
                for (int r = 0; r < num_records; r++)
                begin
                        wait_for_retire(r);
                        check_value($sformatf("record %0d rd", r), patterns[rec_base + 2 * r],
                                    rv_pkg::word_t'(o_wb_rd));
                        check_value($sformatf("record %0d data", r),
                                    patterns[rec_base + 2 * r + 1], o_wb_data);
                end
                check_quiet();

                if (risc_v_inst.risc_v_sva_inst.failures != 0)
                begin
                        $display("An assertion in the bound checker failed");
                        abort_run();
                end
                else
                begin
                        $display("Simulation passed");
                        $finish;
                end
        end

endmodule

`default_nettype wire

// ==== testbench/risc_v_patterns.txt ====
// Word 0 is the program length, then the program words, then the record count
// Each record is rd and its expected write-back data, in retire order
0000001F
00500093 // 00 addi x1, x0, 5
00C00113 // 01 addi x2, x0, 12
FFD00193 // 02 addi x3, x0, -3
0F006213 // 03 ori  x4, x0, 0xf0
001092B3 // 04 sll  x5, x1, x1
0020E333 // 05 or   x6, x1, x2
001143B3 // 06 xor  x7, x2, x1
0011A433 // 07 slt  x8, x3, x1
001254B3 // 08 srl  x9, x4, x1
06400513 // 09 addi x10, x0, 100
00A505B3 // 10 add  x11, x10, x10   EX/MEM on both operands
40A58633 // 11 sub  x12, x11, x10   EX/MEM and MEM/WB
00C506B3 // 12 add  x13, x10, x12   register file bypass and EX/MEM
00100713 // 13 addi x14, x0, 1
00200713 // 14 addi x14, x0, 2
00E707B3 // 15 add  x15, x14, x14   both stages match, EX/MEM wins
00F02423 // 16 sw   x15, 8(x0)      store data from EX/MEM
00302623 // 17 sw   x3, 12(x0)
00802803 // 18 lw   x16, 8(x0)
00C02883 // 19 lw   x17, 12(x0)
00708013 // 20 addi x0, x1, 7       no retire
00300913 // 21 addi x18, x0, 3      x0 must not forward
00F80663 // 22 beq  x16, x15, +12   taken
05500993 // 23 addi x19, x0, 0x55   delay slot
06600A13 // 24 addi x20, x0, 0x66   skipped
00D59663 // 25 bne  x11, x13, +12   not taken
07700A93 // 26 addi x21, x0, 0x77   delay slot
08800B13 // 27 addi x22, x0, 0x88   fall through
00006BB3 // 28 or   x23, x0, x0
00000063 // 29 beq  x0, x0, 0       park loop
00000013 // 30 addi x0, x0, 0       loop delay slot
00000017
01 00000005  02 0000000C  03 FFFFFFFD
04 000000F0  05 000000A0  06 0000000D
07 00000009  08 00000001  09 00000007
0A 00000064  0B 000000C8  0C 00000064
0D 000000C8  0E 00000001  0E 00000002
0F 00000004  10 00000004  11 FFFFFFFD
12 00000003  13 00000055  15 00000077
16 00000088  17 00000000

// ==== list.f ====
+incdir+include
hw/rv_pkg.sv
hw/pipeline_if.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/register_file.sv
hw/execute.sv
hw/memory_writeback.sv
hw/risc_v.sv
testbench/risc_v_sva.sv
testbench/tb_risc_v.sv
